// File: verilog/tcb_pkg.sv
// tcb access engine shared types, opcode and decoder state encodings, width defaults
package tcb_pkg;

  ////////////////////////////////////////
  // width defaults
  ////////////////////////////////////////

  // byte address width
  localparam int unsigned ABW_DEF   = 16;
  // bus data width, multiple of 8
  localparam int unsigned DBW_DEF   = 32;
  // command length field, holds 1..MAX_LEN
  localparam int unsigned LEN_W_DEF = 4;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // access direction
  // matches the bus wen polarity
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } acc_op_e;

  // decoder FSM
  // idle  -> waiting for a command
  // issue -> handing descriptors to execute
  // wait  -> all handed over, waiting for result done
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_issue = 2'd1,
    st_wait  = 2'd2
  } dec_state_e;

endpackage: tcb_pkg

// File: verilog/tcb_acc_decode.sv
// access decoder, splits a byte command into word-aligned transfer descriptors
`timescale 1ns/1ps

module tcb_acc_decode
  import tcb_pkg::*;
#(
  parameter int unsigned ABW     = ABW_DEF,
  parameter int unsigned DBW     = DBW_DEF,
  parameter int unsigned MAX_LEN = 8,
  parameter int unsigned LEN_W   = LEN_W_DEF
)(
  input  logic                      tcb,
  input  logic                      rst_n,
  // command port
  input  logic                      cmd_vld,
  input  acc_op_e                   cmd_op,
  input  logic [ABW-1:0]            cmd_adr,
  input  logic [LEN_W-1:0]          cmd_len,
  input  logic [8*MAX_LEN-1:0]      cmd_wdt,
  output logic                      cmd_rdy,
  // end of access, from result
  input  logic                      done,
  // access summary to result
  output logic                      acc_start,
  output acc_op_e                   acc_op,
  output logic [$clog2(DBW/8)-1:0]  acc_off,
  output logic [LEN_W-1:0]          acc_len,
  output logic [LEN_W-1:0]          acc_num,
  // descriptor to execute
  output logic                      dsc_vld,
  output logic                      dsc_wen,
  output logic [ABW-1:0]            dsc_adr,
  output logic [DBW/8-1:0]          dsc_ben,
  output logic [DBW-1:0]            dsc_wdt,
  input  logic                      dsc_take
);

  localparam int unsigned BEW = DBW/8;
  localparam int unsigned OFW = $clog2(BEW);
  // wide enough for len + offset + rounding
  localparam int unsigned SPW = LEN_W + OFW + 1;

  dec_state_e           state;
  // index of the descriptor on offer
  logic [LEN_W-1:0]     idx;
  logic                 acc;
  logic [SPW-1:0]       span;
  // latched command
  logic [ABW-1:0]       base_r;
  logic [8*MAX_LEN-1:0] wdt_r;

  ////////////////////////////////////////
  // command acceptance
  ////////////////////////////////////////

  assign cmd_rdy = (state == st_idle);
  assign acc     = cmd_vld && cmd_rdy;

  // bytes from start of first word to end of access, rounded up to whole words
  assign span = SPW'(cmd_len) + SPW'(cmd_adr[OFW-1:0]) + SPW'(BEW-1);

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      state     <= st_idle;
      idx       <= '0;
      acc_start <= 1'b0;
    end else begin
      acc_start <= acc;
      case (state)
        st_idle: begin
          if (acc) begin
            state <= st_issue;
            idx   <= '0;
          end
        end
        st_issue: begin
          if (dsc_take) begin
            // last word handed over
            if (idx == acc_num - 1'b1) begin
              state <= st_wait;
            end
            idx <= idx + 1'b1;
          end
        end
        st_wait: begin
          if (done) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // command fields, held for the whole access
  always_ff @(posedge tcb) begin
    if (acc) begin
      acc_op  <= cmd_op;
      acc_off <= cmd_adr[OFW-1:0];
      acc_len <= cmd_len;
      acc_num <= LEN_W'(span >> OFW);
      base_r  <= {cmd_adr[ABW-1:OFW], {OFW{1'b0}}};
      wdt_r   <= cmd_wdt;
    end
  end

  ////////////////////////////////////////
  // descriptor generation
  ////////////////////////////////////////

  assign dsc_vld = (state == st_issue);
  assign dsc_wen = (acc_op == op_write);
  // word aligned, one word per index
  assign dsc_adr = base_r + (ABW'(idx) << OFW);

  // lane b of word idx holds access byte idx*BEW + b - off
  always_comb begin : lane_map
    int pos;
    int j;
    dsc_ben = '0;
    dsc_wdt = '0;
    for (int b = 0; b < int'(BEW); b++) begin
      pos = int'(idx) * int'(BEW) + b;
      j   = pos - int'(acc_off);
      // only bytes inside the access get an enable
      if (j >= 0 && j < int'(acc_len) && j < int'(MAX_LEN)) begin
        dsc_ben[b]        = 1'b1;
        dsc_wdt[8*b +: 8] = wdt_r[8*j +: 8];
      end
    end
  end

endmodule: tcb_acc_decode

// File: verilog/tcb_acc_execute.sv
// request stage, places descriptors on the tcb request signals and holds them under stall
`timescale 1ns/1ps

module tcb_acc_execute
  import tcb_pkg::*;
#(
  parameter int unsigned ABW = ABW_DEF,
  parameter int unsigned DBW = DBW_DEF
)(
  input  logic             tcb,
  input  logic             rst_n,
  // descriptor from decode
  input  logic             dsc_vld,
  input  logic             dsc_wen,
  input  logic [ABW-1:0]   dsc_adr,
  input  logic [DBW/8-1:0] dsc_ben,
  input  logic [DBW-1:0]   dsc_wdt,
  output logic             dsc_take,
  // tcb request
  output logic             vld,
  output logic             wen,
  output logic [ABW-1:0]   adr,
  output logic [DBW/8-1:0] ben,
  output logic [DBW-1:0]   wdt,
  input  logic             rdy
);

  localparam int unsigned BEW = DBW/8;

  // request register
  logic           wen_r;
  logic [ABW-1:0] adr_r;
  logic [BEW-1:0] ben_r;
  logic [DBW-1:0] wdt_r;

  // slot is free when empty or its transfer completes this cycle
  // so the next word follows back to back
  assign dsc_take = dsc_vld && (!vld || rdy);

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      vld <= 1'b0;
    end else if (!vld || rdy) begin
      vld <= dsc_vld;
    end
  end

  // payload only moves on hand-over
  // stays put while vld && !rdy
  always_ff @(posedge tcb) begin
    if (dsc_take) begin
      wen_r <= dsc_wen;
      adr_r <= dsc_adr;
      ben_r <= dsc_ben;
      wdt_r <= dsc_wdt;
    end
  end

  ////////////////////////////////////////
  // bus drive
  ////////////////////////////////////////

  // defined zeros between transfers
  assign wen = vld & wen_r;
  assign adr = vld ? adr_r : '0;
  assign ben = vld ? ben_r : '0;
  assign wdt = vld ? wdt_r : '0;

endmodule: tcb_acc_execute

// File: verilog/tcb_acc_result.sv
// response stage, reassembles read bytes, merges errors and signals access done
`timescale 1ns/1ps

module tcb_acc_result
  import tcb_pkg::*;
#(
  parameter int unsigned DBW     = DBW_DEF,
  parameter int unsigned MAX_LEN = 8,
  parameter int unsigned LEN_W   = LEN_W_DEF
)(
  input  logic                      tcb,
  input  logic                      rst_n,
  // access summary from decode
  input  logic                      acc_start,
  input  acc_op_e                   acc_op,
  input  logic [$clog2(DBW/8)-1:0]  acc_off,
  input  logic [LEN_W-1:0]          acc_len,
  input  logic [LEN_W-1:0]          acc_num,
  // tcb response
  input  logic                      rsp,
  input  logic [DBW-1:0]            rdt,
  input  logic                      err,
  // access result
  output logic                      done,
  output logic [8*MAX_LEN-1:0]      done_rdt,
  output logic                      done_err
);

  localparam int unsigned BEW = DBW/8;
  localparam int unsigned OFW = $clog2(BEW);

  // latched access summary
  acc_op_e              op_r;
  logic [OFW-1:0]       off_r;
  logic [LEN_W-1:0]     len_r;
  logic [LEN_W-1:0]     num_r;
  // responses seen so far, also the word index of the current one
  logic [LEN_W-1:0]     cnt;
  logic [8*MAX_LEN-1:0] rdt_nxt;

  ////////////////////////////////////////
  // byte placement
  ////////////////////////////////////////

  // lane b of word cnt is access byte cnt*BEW + b - off
  // lanes outside the access are dropped, so upper bytes stay zero
  always_comb begin : place
    int pos;
    int j;
    rdt_nxt = done_rdt;
    for (int b = 0; b < int'(BEW); b++) begin
      pos = int'(cnt) * int'(BEW) + b;
      j   = pos - int'(off_r);
      if (j >= 0 && j < int'(len_r) && j < int'(MAX_LEN)) begin
        rdt_nxt[8*j +: 8] = rdt[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // counting and completion
  ////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      cnt      <= '0;
      done     <= 1'b0;
      done_err <= 1'b0;
    end else begin
      // one cycle after the last response
      done <= rsp && (cnt == num_r - 1'b1);
      if (acc_start) begin
        cnt      <= '0;
        done_err <= 1'b0;
      end else if (rsp) begin
        cnt      <= cnt + 1'b1;
        done_err <= done_err | err;
      end
    end
  end

  // summary and read buffer
  always_ff @(posedge tcb) begin
    if (acc_start) begin
      op_r     <= acc_op;
      off_r    <= acc_off;
      len_r    <= acc_len;
      num_r    <= acc_num;
      done_rdt <= '0;
    end else if (rsp && op_r == op_read) begin
      // writes leave the buffer cleared
      done_rdt <= rdt_nxt;
    end
  end

endmodule: tcb_acc_result

// File: verilog/tcb_mem_sub.sv
// tcb subordinate memory with byte enables, external stall and out of range error
`timescale 1ns/1ps

module tcb_mem_sub
  import tcb_pkg::*;
#(
  parameter int unsigned ABW    = ABW_DEF,
  parameter int unsigned DBW    = DBW_DEF,
  parameter int unsigned MEM_AW = 6
)(
  input  logic             tcb,
  input  logic             rst_n,
  // back-pressure source
  input  logic             stall,
  // tcb request
  input  logic             vld,
  input  logic             wen,
  input  logic [ABW-1:0]   adr,
  input  logic [DBW/8-1:0] ben,
  input  logic [DBW-1:0]   wdt,
  output logic             rdy,
  // tcb response
  output logic             rsp,
  output logic [DBW-1:0]   rdt,
  output logic             err
);

  localparam int unsigned BEW = DBW/8;
  localparam int unsigned OFW = $clog2(BEW);

  logic [DBW-1:0]    mem [2**MEM_AW];
  logic              trn;
  logic              in_rng;
  logic [MEM_AW-1:0] wa;

  assign rdy = !stall;
  assign trn = vld && rdy;

  // word address must fit below 2^MEM_AW
  assign in_rng = ((adr[ABW-1:OFW] >> MEM_AW) == '0);
  assign wa     = adr[OFW +: MEM_AW];

  ////////////////////////////////////////
  // response pipeline
  ////////////////////////////////////////

  // exactly one response per transfer, next cycle
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rsp <= 1'b0;
    end else begin
      rsp <= trn;
    end
  end

  always_ff @(posedge tcb) begin
    if (trn) begin
      err <= !in_rng;
      // full word on reads, zero for writes and errors
      if (wen || !in_rng) begin
        rdt <= '0;
      end else begin
        rdt <= mem[wa];
      end
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // out of range writes are dropped
  always_ff @(posedge tcb) begin
    if (trn && wen && in_rng) begin
      for (int b = 0; b < int'(BEW); b++) begin
        if (ben[b]) begin
          mem[wa][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

endmodule: tcb_mem_sub

// File: verilog/tcb_acc_top.sv
// byte access engine top, decode, execute and result driving the subordinate memory
`timescale 1ns/1ps

module tcb_acc_top
  import tcb_pkg::*;
#(
  parameter int unsigned ABW     = ABW_DEF,
  parameter int unsigned DBW     = DBW_DEF,
  parameter int unsigned MAX_LEN = 8,
  parameter int unsigned LEN_W   = LEN_W_DEF,
  parameter int unsigned MEM_AW  = 6
)(
  input  logic                 tcb,
  input  logic                 rst_n,
  // command port
  input  logic                 cmd_vld,
  input  acc_op_e              cmd_op,
  input  logic [ABW-1:0]       cmd_adr,
  input  logic [LEN_W-1:0]     cmd_len,
  input  logic [8*MAX_LEN-1:0] cmd_wdt,
  output logic                 cmd_rdy,
  // memory back-pressure
  input  logic                 stall,
  // access result
  output logic                 done,
  output logic [8*MAX_LEN-1:0] done_rdt,
  output logic                 done_err
);

  localparam int unsigned BEW = DBW/8;
  localparam int unsigned OFW = $clog2(BEW);

  // decode to result
  logic             acc_start;
  acc_op_e          acc_op;
  logic [OFW-1:0]   acc_off;
  logic [LEN_W-1:0] acc_len;
  logic [LEN_W-1:0] acc_num;
  // decode to execute
  logic             dsc_vld;
  logic             dsc_wen;
  logic [ABW-1:0]   dsc_adr;
  logic [BEW-1:0]   dsc_ben;
  logic [DBW-1:0]   dsc_wdt;
  logic             dsc_take;
  // tcb bus
  logic             vld;
  logic             wen;
  logic [ABW-1:0]   adr;
  logic [BEW-1:0]   ben;
  logic [DBW-1:0]   wdt;
  logic             rdy;
  logic             rsp;
  logic [DBW-1:0]   rdt;
  logic             err;

  tcb_acc_decode #(
    .ABW     (ABW),
    .DBW     (DBW),
    .MAX_LEN (MAX_LEN),
    .LEN_W   (LEN_W)
  ) u_decode (
    .tcb       (tcb),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_op    (cmd_op),
    .cmd_adr   (cmd_adr),
    .cmd_len   (cmd_len),
    .cmd_wdt   (cmd_wdt),
    .cmd_rdy   (cmd_rdy),
    .done      (done),
    .acc_start (acc_start),
    .acc_op    (acc_op),
    .acc_off   (acc_off),
    .acc_len   (acc_len),
    .acc_num   (acc_num),
    .dsc_vld   (dsc_vld),
    .dsc_wen   (dsc_wen),
    .dsc_adr   (dsc_adr),
    .dsc_ben   (dsc_ben),
    .dsc_wdt   (dsc_wdt),
    .dsc_take  (dsc_take)
  );

  tcb_acc_execute #(
    .ABW (ABW),
    .DBW (DBW)
  ) u_execute (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .dsc_vld  (dsc_vld),
    .dsc_wen  (dsc_wen),
    .dsc_adr  (dsc_adr),
    .dsc_ben  (dsc_ben),
    .dsc_wdt  (dsc_wdt),
    .dsc_take (dsc_take),
    .vld      (vld),
    .wen      (wen),
    .adr      (adr),
    .ben      (ben),
    .wdt      (wdt),
    .rdy      (rdy)
  );

  tcb_acc_result #(
    .DBW     (DBW),
    .MAX_LEN (MAX_LEN),
    .LEN_W   (LEN_W)
  ) u_result (
    .tcb       (tcb),
    .rst_n     (rst_n),
    .acc_start (acc_start),
    .acc_op    (acc_op),
    .acc_off   (acc_off),
    .acc_len   (acc_len),
    .acc_num   (acc_num),
    .rsp       (rsp),
    .rdt       (rdt),
    .err       (err),
    .done      (done),
    .done_rdt  (done_rdt),
    .done_err  (done_err)
  );

  tcb_mem_sub #(
    .ABW    (ABW),
    .DBW    (DBW),
    .MEM_AW (MEM_AW)
  ) u_mem (
    .tcb   (tcb),
    .rst_n (rst_n),
    .stall (stall),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdy   (rdy),
    .rsp   (rsp),
    .rdt   (rdt),
    .err   (err)
  );

endmodule: tcb_acc_top

// File: sim/tcb_acc_checker.sv
// protocol checker for the tcb bus and the command port, bound into the engine top
`timescale 1ns/1ps

module tcb_acc_checker
  import tcb_pkg::*;
#(
  parameter int unsigned ABW = ABW_DEF,
  parameter int unsigned DBW = DBW_DEF
)(
  input logic             tcb,
  input logic             rst_n,
  input logic             cmd_vld,
  input logic             cmd_rdy,
  input logic             done,
  input logic             vld,
  input logic             rdy,
  input logic             wen,
  input logic [ABW-1:0]   adr,
  input logic [DBW/8-1:0] ben,
  input logic [DBW-1:0]   wdt,
  input logic             rsp,
  input dec_state_e       state
);

  ////////////////////////////////////////
  // bus rules
  ////////////////////////////////////////

  // stalled request keeps all fields
  a_req_hold: assert property (@(posedge tcb) disable iff (!rst_n)
    vld && !rdy |=> vld && $stable(wen) && $stable(adr) && $stable(ben) && $stable(wdt))
    else $error("request changed while stalled");

  // one response per transfer, next cycle
  a_rsp_timing: assert property (@(posedge tcb) disable iff (!rst_n)
    rsp == $past(vld && rdy))
    else $error("response not one cycle after transfer");

  ////////////////////////////////////////
  // command rules
  ////////////////////////////////////////

  a_done_busy: assert property (@(posedge tcb) disable iff (!rst_n)
    done |-> !cmd_rdy)
    else $error("done while command port ready");

  // idle only left on a handshake
  a_idle_exit: assert property (@(posedge tcb) disable iff (!rst_n)
    (state == st_idle) && !(cmd_vld && cmd_rdy) |=> state == st_idle)
    else $error("decoder left idle without a command");

endmodule: tcb_acc_checker

bind tcb_acc_top tcb_acc_checker #(
  .ABW (ABW),
  .DBW (DBW)
) u_checker (
  .tcb     (tcb),
  .rst_n   (rst_n),
  .cmd_vld (cmd_vld),
  .cmd_rdy (cmd_rdy),
  .done    (done),
  .vld     (vld),
  .rdy     (rdy),
  .wen     (wen),
  .adr     (adr),
  .ben     (ben),
  .wdt     (wdt),
  .rsp     (rsp),
  .state   (u_decode.state)
);

// File: sim/tcb_acc_tb.sv
// testbench for the byte access engine, directed and random accesses against a byte model
`timescale 1ns/1ps

module tcb_acc_tb
  import tcb_pkg::*;
;

  localparam int unsigned ABW       = 16;
  localparam int unsigned DBW       = 32;
  localparam int unsigned MAX_LEN   = 8;
  localparam int unsigned LEN_W     = 4;
  localparam int unsigned MEM_AW    = 6;
  localparam int unsigned MEM_BYTES = (DBW/8) * (2**MEM_AW);
  localparam int          CLK_PER   = 100;
  // per access bound, worst case with stall
  localparam int          DONE_BOUND = MAX_LEN + 20;
  // fill 32, directed 16, random 40, plus spare
  localparam int          NUM_CMDS  = 100;
  localparam int          WDOG_CYC  = NUM_CMDS * DONE_BOUND + 200;

  logic                 tcb;
  logic                 rst_n;
  logic                 cmd_vld;
  acc_op_e              cmd_op;
  logic [ABW-1:0]       cmd_adr;
  logic [LEN_W-1:0]     cmd_len;
  logic [8*MAX_LEN-1:0] cmd_wdt;
  logic                 cmd_rdy;
  logic                 stall;
  logic                 done;
  logic [8*MAX_LEN-1:0] done_rdt;
  logic                 done_err;

  // byte model of the memory
  logic [7:0]  ref_mem [MEM_BYTES];
  logic [31:0] lcg_state;
  // random stall enable
  bit          rand_stall;

  tcb_acc_top #(
    .ABW     (ABW),
    .DBW     (DBW),
    .MAX_LEN (MAX_LEN),
    .LEN_W   (LEN_W),
    .MEM_AW  (MEM_AW)
  ) u_dut (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_op   (cmd_op),
    .cmd_adr  (cmd_adr),
    .cmd_len  (cmd_len),
    .cmd_wdt  (cmd_wdt),
    .cmd_rdy  (cmd_rdy),
    .stall    (stall),
    .done     (done),
    .done_rdt (done_rdt),
    .done_err (done_err)
  );

  initial begin
    tcb = 1'b0;
    forever #(CLK_PER/2) tcb = ~tcb;
  end

  // hard stop if an access hangs
  initial begin
    #(WDOG_CYC * CLK_PER);
    $display("watchdog expired before all tests finished");
    $display("Test failed");
    $fatal(1);
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // fill value, mixes all address bits
  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 29) ^ (a >> 3) ^ 8'ha5);
  endfunction

  // words touched = ceil((len + offset) / bytes per word)
  function automatic int xfer_count(input logic [ABW-1:0] adr, input int len);
    return (len + int'(adr % (DBW/8)) + DBW/8 - 1) / (DBW/8);
  endfunction

  // sit 1 ns past the rising edge
  task automatic step();
    @(posedge tcb);
    #1;
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("error: %s", what);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // one command on the port, optional stray pulse while busy
  task automatic run_cmd(input acc_op_e op, input logic [ABW-1:0] adr, input int len,
                         input logic [63:0] wdt, input bit poke,
                         output logic [63:0] rdt, output logic err, output int cycles);
    int          waited;
    logic [31:0] r;
    waited = 0;
    while (!cmd_rdy) begin
      step();
      waited++;
      check_true(waited < DONE_BOUND, "engine never became ready for a command");
    end
    cmd_vld = 1'b1;
    cmd_op  = op;
    cmd_adr = adr;
    cmd_len = LEN_W'(len);
    cmd_wdt = wdt;
    cycles  = 0;
    do begin
      step();
      cycles++;
      if (poke && cycles == 1) begin
        // different write, must be dropped
        check_true(!cmd_rdy, "cmd_rdy high while an access is in progress");
        cmd_op  = op_write;
        cmd_adr = adr ^ 16'h0080;
        cmd_len = LEN_W'(MAX_LEN);
        cmd_wdt = ~wdt;
      end else begin
        cmd_vld = 1'b0;
      end
      r     = lcg_next();
      stall = rand_stall && (r[31:30] == 2'b00);
      check_true(cycles < DONE_BOUND, "no done within the cycle bound");
    end while (!done);
    rdt   = done_rdt;
    err   = done_err;
    stall = 1'b0;
  endtask

  // access with expected result from the byte model
  task automatic access(input acc_op_e op, input logic [ABW-1:0] adr, input int len,
                        input logic [63:0] wdt, input bit poke, output int cycles);
    logic [63:0] exp_rdt;
    logic        exp_err;
    logic [63:0] got_rdt;
    logic        got_err;
    int          a;
    exp_rdt = '0;
    exp_err = 1'b0;
    for (int i = 0; i < len; i++) begin
      a = int'(adr) + i;
      if (a >= int'(MEM_BYTES)) begin
        exp_err = 1'b1;
      end else if (op == op_read) begin
        exp_rdt[8*i +: 8] = ref_mem[a];
      end
    end
    run_cmd(op, adr, len, wdt, poke, got_rdt, got_err, cycles);
    check_eq("done_err", 64'(got_err), 64'(exp_err));
    check_eq("done_rdt", got_rdt, exp_rdt);
    // in range bytes land, the rest is dropped
    if (op == op_write) begin
      for (int i = 0; i < len; i++) begin
        a = int'(adr) + i;
        if (a < int'(MEM_BYTES)) begin
          ref_mem[a] = wdt[8*i +: 8];
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    check_eq("cmd_rdy", 64'(cmd_rdy), 64'd1);
    check_eq("done", 64'(done), 64'd0);
  endtask

  // every location written before any read
  task automatic fill_memory();
    logic [63:0] w;
    int          cyc;
    for (int a = 0; a < int'(MEM_BYTES); a += 8) begin
      for (int i = 0; i < 8; i++) begin
        w[8*i +: 8] = fill_byte(a + i);
      end
      access(op_write, ABW'(a), 8, w, 1'b0, cyc);
    end
  endtask

  task automatic test_aligned();
    int cyc;
    access(op_write, 16'h0010, 4, 64'h0000_0000_c0de_beef, 1'b0, cyc);
    check_eq("latency", 64'(cyc), 64'(xfer_count(16'h0010, 4) + 3));
    access(op_read, 16'h0010, 4, '0, 1'b0, cyc);
    check_eq("latency", 64'(cyc), 64'(xfer_count(16'h0010, 4) + 3));
    access(op_write, 16'h0018, 8, 64'h0123_4567_89ab_cdef, 1'b0, cyc);
    access(op_read, 16'h0018, 8, '0, 1'b0, cyc);
    check_eq("latency", 64'(cyc), 64'(xfer_count(16'h0018, 8) + 3));
  endtask

  // offset 3, length 6, three words
  task automatic test_misaligned();
    int cyc;
    access(op_write, 16'h0043, 6, 64'h0000_6655_4433_2211, 1'b0, cyc);
    check_eq("latency", 64'(cyc), 64'(xfer_count(16'h0043, 6) + 3));
    access(op_read, 16'h0040, 4, '0, 1'b0, cyc);
    access(op_read, 16'h0044, 4, '0, 1'b0, cyc);
    access(op_read, 16'h0048, 4, '0, 1'b0, cyc);
    access(op_read, 16'h0043, 6, '0, 1'b0, cyc);
  endtask

  // straddles the top of memory
  task automatic test_out_of_range();
    int cyc;
    access(op_write, 16'h00fd, 8, 64'hfeed_face_0bad_f00d, 1'b0, cyc);
    access(op_read, 16'h00fc, 4, '0, 1'b0, cyc);
    access(op_read, 16'h00fd, 8, '0, 1'b0, cyc);
    access(op_read, 16'h1000, 4, '0, 1'b0, cyc);
  endtask

  task automatic test_random();
    logic [31:0]    r;
    logic [ABW-1:0] adr;
    logic [63:0]    w;
    int             cyc;
    rand_stall = 1'b1;
    for (int n = 0; n < 40; n++) begin
      r   = lcg_next();
      adr = ABW'(lcg_next() % 32'd280);
      w   = {lcg_next(), lcg_next()};
      access(r[31] ? op_write : op_read, adr, int'(r[30:28]) + 1, w, 1'b0, cyc);
    end
    rand_stall = 1'b0;
  endtask

  // stray pulse aims at 0xa0, which must keep its old bytes
  task automatic test_ignored_cmd();
    int cyc;
    access(op_write, 16'h0020, 4, 64'h0000_0000_5a5a_a5a5, 1'b1, cyc);
    access(op_read, 16'h00a0, 8, '0, 1'b0, cyc);
    access(op_read, 16'h0020, 4, '0, 1'b0, cyc);
  endtask

  initial begin
    lcg_state  = 32'h25afd324;
    rand_stall = 1'b0;
    rst_n      = 1'b0;
    cmd_vld    = 1'b0;
    cmd_op     = op_read;
    cmd_adr    = '0;
    cmd_len    = '0;
    cmd_wdt    = '0;
    stall      = 1'b0;
    repeat (2) step();
    rst_n = 1'b1;
    test_reset();
    fill_memory();
    test_aligned();
    test_misaligned();
    test_out_of_range();
    test_random();
    test_ignored_cmd();
    $display("Test completed successfully");
    $finish;
  end

endmodule: tcb_acc_tb

// File: project.f
verilog/tcb_pkg.sv
verilog/tcb_acc_decode.sv
verilog/tcb_acc_execute.sv
verilog/tcb_acc_result.sv
verilog/tcb_mem_sub.sv
verilog/tcb_acc_top.sv
sim/tcb_acc_checker.sv
sim/tcb_acc_tb.sv

// File: Makefile
# Verilator build for the tcb byte access engine

VERILATOR ?= verilator
TOP       ?= tcb_acc_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
